//--- rob_cfg_pkg.sv
package rob_cfg_pkg;

	// ----------------------------------------
	// buffer geometry
	// ----------------------------------------
	localparam int unsigned ROB_DEPTH = 32;
	localparam int unsigned ROB_IDX_W = 5; // log2 of ROB_DEPTH

	// ----------------------------------------
	// rename and branch field widths
	// ----------------------------------------
	localparam int unsigned PRF_TAG_W = 6;
	localparam int unsigned AREG_W    = 5;
	localparam int unsigned FL_HEAD_W = 5;
	localparam int unsigned BR_MASK_W = 4;
	localparam int unsigned PC_W      = 64;

	localparam int unsigned INSTR_BYTES = 4;  // fixed instruction size
	localparam int unsigned NULL_TAG    = 31; // tag of an empty or retired entry

endpackage

//--- rob_types_pkg.sv
package rob_types_pkg;

	import rob_cfg_pkg::*;

	// ----------------------------------------
	// pointers and indices
	// ----------------------------------------
	typedef logic [ROB_IDX_W:0]   rob_ptr_t; // msb is the wrap bit
	typedef logic [ROB_IDX_W-1:0] rob_idx_t;

	// ----------------------------------------
	// entry fields
	// ----------------------------------------
	typedef logic [PRF_TAG_W-1:0] prf_tag_t;
	typedef logic [AREG_W-1:0]    areg_t;
	typedef logic [FL_HEAD_W-1:0] fl_head_t;
	typedef logic [BR_MASK_W-1:0] br_mask_t;
	typedef logic [PC_W-1:0]      pc_t;

	// result of a branch resolve, replaces separate right/recover flags
	typedef enum logic [1:0] {
		BR_NONE       = 2'd0,
		BR_CORRECT    = 2'd1,
		BR_MISPREDICT = 2'd2
	} br_outcome_e;

endpackage

//--- rob_ptrs.sv
`timescale 1ns/1ps

module rob_ptrs (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    dispatch_i,
	input  logic                    head_done_i,
	input  logic                    rollback_i,
	input  rob_types_pkg::rob_idx_t rollback_idx_i,
	output rob_types_pkg::rob_idx_t head_idx_o,
	output rob_types_pkg::rob_idx_t tail_idx_o,
	output rob_types_pkg::rob_ptr_t tail_ptr_o,
	output logic                    alloc_en_o,
	output logic                    retire_vld_o,
	output logic                    stall_o
);
	import rob_cfg_pkg::*;
	import rob_types_pkg::*;

	rob_ptr_t head_r;
	rob_ptr_t tail_r;
	rob_ptr_t br_ptr; // full pointer of the resolving branch
	logic     br_wrap;
	logic     empty;
	logic     full;

	// ----------------------------------------
	// occupancy
	// ----------------------------------------
	assign empty = (head_r == tail_r);

	// same index on opposite laps
	assign full = (head_r[ROB_IDX_W] != tail_r[ROB_IDX_W]) &&
		(head_r[ROB_IDX_W-1:0] == tail_r[ROB_IDX_W-1:0]);

	assign retire_vld_o = head_done_i & ~empty;
	assign stall_o      = full & ~retire_vld_o; // a retiring head frees a slot this cycle

	// rollback wins over a dispatch in the same cycle
	assign alloc_en_o = dispatch_i & ~stall_o & ~rollback_i;

	assign head_idx_o = head_r[ROB_IDX_W-1:0];
	assign tail_idx_o = tail_r[ROB_IDX_W-1:0];
	assign tail_ptr_o = tail_r;

	// ----------------------------------------
	// rollback target
	// ----------------------------------------
	// an index behind the tail index is on the tail's lap,
	// anything else was allocated on the lap before
	assign br_wrap = (rollback_idx_i < tail_r[ROB_IDX_W-1:0]) ?
		tail_r[ROB_IDX_W] : ~tail_r[ROB_IDX_W];
	assign br_ptr = {br_wrap, rollback_idx_i};

	always_ff @(posedge clk) begin
		if (rst) begin
			head_r <= '0;
			tail_r <= '0;
		end else begin
			if (retire_vld_o)
				head_r <= head_r + rob_ptr_t'(1);

			if (rollback_i)
				tail_r <= br_ptr + rob_ptr_t'(1); // first slot after the branch
			else if (alloc_en_o)
				tail_r <= tail_r + rob_ptr_t'(1);
		end
	end

endmodule

//--- rob_entry_store.sv
`timescale 1ns/1ps

module rob_entry_store (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      alloc_en_i,
	input  rob_types_pkg::rob_idx_t   tail_idx_i,
	input  rob_types_pkg::prf_tag_t   new_tag_i,
	input  rob_types_pkg::prf_tag_t   old_tag_i,
	input  rob_types_pkg::areg_t      areg_i,
	input  rob_types_pkg::fl_head_t   fl_head_i,
	input  logic                      complete_i,
	input  rob_types_pkg::rob_idx_t   complete_idx_i,
	input  logic                      retire_i,
	input  rob_types_pkg::rob_idx_t   head_idx_i,
	input  rob_types_pkg::rob_idx_t   recover_idx_i,
	output logic                      head_done_o,
	output rob_types_pkg::prf_tag_t   head_new_tag_o,
	output rob_types_pkg::prf_tag_t   head_old_tag_o,
	output rob_types_pkg::areg_t      head_areg_o,
	output rob_types_pkg::fl_head_t   recover_fl_head_o
);
	import rob_cfg_pkg::*;
	import rob_types_pkg::*;

	prf_tag_t             new_tag_r [0:ROB_DEPTH-1];
	prf_tag_t             old_tag_r [0:ROB_DEPTH-1];
	areg_t                areg_r    [0:ROB_DEPTH-1];
	fl_head_t             fl_head_r [0:ROB_DEPTH-1]; // free-list head at dispatch
	logic [ROB_DEPTH-1:0] done_r;

	// ----------------------------------------
	// tags and done bits
	// ----------------------------------------
	// when full and retiring, head and tail share an index and the
	// allocation below must land on top of the retire clear
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < ROB_DEPTH; i++) begin
				new_tag_r[i] <= prf_tag_t'(NULL_TAG);
				old_tag_r[i] <= prf_tag_t'(NULL_TAG);
			end
			done_r <= '0;
		end else begin
			if (retire_i) begin
				new_tag_r[head_idx_i] <= prf_tag_t'(NULL_TAG);
				old_tag_r[head_idx_i] <= prf_tag_t'(NULL_TAG);
				done_r[head_idx_i]    <= 1'b0;
			end
			if (alloc_en_i) begin
				new_tag_r[tail_idx_i] <= new_tag_i;
				old_tag_r[tail_idx_i] <= old_tag_i;
				done_r[tail_idx_i]    <= 1'b0;
			end
			if (complete_i)
				done_r[complete_idx_i] <= 1'b1; // fu finished this entry
		end
	end

	// destination and free-list head only matter while allocated
	always_ff @(posedge clk) begin
		if (alloc_en_i) begin
			areg_r[tail_idx_i]    <= areg_i;
			fl_head_r[tail_idx_i] <= fl_head_i;
		end
	end

	// ----------------------------------------
	// read ports
	// ----------------------------------------
	assign head_done_o    = done_r[head_idx_i];
	assign head_new_tag_o = new_tag_r[head_idx_i]; // to arch map
	assign head_old_tag_o = old_tag_r[head_idx_i]; // back to free list
	assign head_areg_o    = areg_r[head_idx_i];

	assign recover_fl_head_o = fl_head_r[recover_idx_i];

endmodule

//--- rob_branch_store.sv
`timescale 1ns/1ps

module rob_branch_store (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      alloc_en_i,
	input  rob_types_pkg::rob_idx_t   tail_idx_i,
	input  rob_types_pkg::pc_t        pc_i,
	input  logic                      br_flag_i,
	input  logic                      br_pretaken_i,
	input  rob_types_pkg::pc_t        br_target_i,
	input  rob_types_pkg::br_mask_t   br_mask_i,
	input  rob_types_pkg::rob_idx_t   npc_idx_i,
	input  rob_types_pkg::rob_idx_t   recover_idx_i,
	output rob_types_pkg::pc_t        npc_o,
	output logic                      rec_br_flag_o,
	output logic                      rec_pretaken_o,
	output rob_types_pkg::pc_t        rec_target_o,
	output rob_types_pkg::br_mask_t   recover_mask_o
);
	import rob_cfg_pkg::*;
	import rob_types_pkg::*;

	pc_t                  pc_r        [0:ROB_DEPTH-1];
	pc_t                  target_r    [0:ROB_DEPTH-1]; // predicted target
	br_mask_t             mask_r      [0:ROB_DEPTH-1];
	logic [ROB_DEPTH-1:0] br_flag_r;
	logic [ROB_DEPTH-1:0] pretaken_r;

	// an unwritten slot must never look like a branch to the resolver
	always_ff @(posedge clk) begin
		if (rst)
			br_flag_r <= '0;
		else if (alloc_en_i)
			br_flag_r[tail_idx_i] <= br_flag_i;
	end

	always_ff @(posedge clk) begin
		if (alloc_en_i) begin
			pc_r[tail_idx_i]       <= pc_i;
			target_r[tail_idx_i]   <= br_target_i;
			mask_r[tail_idx_i]     <= br_mask_i;
			pretaken_r[tail_idx_i] <= br_pretaken_i;
		end
	end

	// ----------------------------------------
	// read ports
	// ----------------------------------------
	// fall-through pc for the branch alu
	assign npc_o = pc_r[npc_idx_i] + pc_t'(INSTR_BYTES);

	assign rec_br_flag_o  = br_flag_r[recover_idx_i];
	assign rec_pretaken_o = pretaken_r[recover_idx_i];
	assign rec_target_o   = target_r[recover_idx_i];
	assign recover_mask_o = mask_r[recover_idx_i];

endmodule

//--- rob_recovery.sv
`timescale 1ns/1ps

module rob_recovery (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         resolve_i,
	input  logic                         resolve_taken_i,
	input  rob_types_pkg::pc_t           resolve_target_i,
	input  logic                         rec_br_flag_i,
	input  logic                         rec_pretaken_i,
	input  rob_types_pkg::pc_t           rec_target_i,
	output rob_types_pkg::br_outcome_e   br_outcome_o,
	output logic                         rollback_o
);
	import rob_cfg_pkg::*;
	import rob_types_pkg::*;

	logic [PC_W-1:0] target_diff;
	logic            pred_hit;
	logic            mark_r; // recovery allowed this cycle

	assign target_diff = resolve_target_i ^ rec_target_i;

	// direction and target must both agree
	assign pred_hit = (resolve_taken_i == rec_pretaken_i) && (target_diff == '0);

	always_comb begin
		br_outcome_o = BR_NONE;
		if (resolve_i && rec_br_flag_i) begin
			if (pred_hit)
				br_outcome_o = BR_CORRECT;
			else if (mark_r)
				br_outcome_o = BR_MISPREDICT;
		end
	end

	assign rollback_o = (br_outcome_o == BR_MISPREDICT);

	// ----------------------------------------
	// one-shot mark
	// ----------------------------------------
	// drops for one cycle after a recovery so a repeated resolve is ignored
	always_ff @(posedge clk) begin
		if (rst)
			mark_r <= 1'b1;
		else
			mark_r <= ~rollback_o;
	end

endmodule

//--- rob_top.sv
`timescale 1ns/1ps

module rob_top (
	input  logic                         clk,
	input  logic                         rst,
	// dispatch from rename
	input  logic                         dispatch_i,
	input  rob_types_pkg::prf_tag_t      new_tag_i,
	input  rob_types_pkg::prf_tag_t      old_tag_i,
	input  rob_types_pkg::areg_t         areg_i,
	input  rob_types_pkg::fl_head_t      fl_head_i,
	input  rob_types_pkg::pc_t           pc_i,
	input  logic                         br_flag_i,
	input  logic                         br_pretaken_i,
	input  rob_types_pkg::pc_t           br_target_i,
	input  rob_types_pkg::br_mask_t      br_mask_i,
	// completion from the functional units
	input  logic                         complete_i,
	input  rob_types_pkg::rob_idx_t      complete_idx_i,
	// branch resolve
	input  logic                         resolve_i,
	input  rob_types_pkg::rob_idx_t      resolve_idx_i,
	input  logic                         resolve_taken_i,
	input  rob_types_pkg::pc_t           resolve_target_i,
	input  rob_types_pkg::rob_idx_t      npc_idx_i,
	output rob_types_pkg::rob_ptr_t      tail_ptr_o,
	output logic                         stall_o,
	output logic                         retire_vld_o,
	output rob_types_pkg::prf_tag_t      retire_old_tag_o,
	output rob_types_pkg::prf_tag_t      retire_new_tag_o,
	output rob_types_pkg::areg_t         retire_areg_o,
	output rob_types_pkg::pc_t           npc_o,
	output rob_types_pkg::br_outcome_e   br_outcome_o,
	output rob_types_pkg::fl_head_t      recover_fl_head_o,
	output rob_types_pkg::br_mask_t      recover_mask_o
);
	import rob_cfg_pkg::*;
	import rob_types_pkg::*;

	logic [ROB_IDX_W-1:0] head_idx;
	logic [ROB_IDX_W-1:0] tail_idx;
	logic                 alloc_en;
	logic                 head_done;
	logic                 rollback;
	logic                 rec_br_flag;
	logic                 rec_pretaken;
	pc_t                  rec_target;

	// ----------------------------------------
	// pointers
	// ----------------------------------------
	rob_ptrs rob_ptrs_i (
		.clk            (clk),
		.rst            (rst),
		.dispatch_i     (dispatch_i),
		.head_done_i    (head_done),
		.rollback_i     (rollback),
		.rollback_idx_i (resolve_idx_i),
		.head_idx_o     (head_idx),
		.tail_idx_o     (tail_idx),
		.tail_ptr_o     (tail_ptr_o),
		.alloc_en_o     (alloc_en),
		.retire_vld_o   (retire_vld_o),
		.stall_o        (stall_o)
	);

	// ----------------------------------------
	// entry storage
	// ----------------------------------------
	rob_entry_store rob_entry_store_i (
		.clk               (clk),
		.rst               (rst),
		.alloc_en_i        (alloc_en),
		.tail_idx_i        (tail_idx),
		.new_tag_i         (new_tag_i),
		.old_tag_i         (old_tag_i),
		.areg_i            (areg_i),
		.fl_head_i         (fl_head_i),
		.complete_i        (complete_i),
		.complete_idx_i    (complete_idx_i),
		.retire_i          (retire_vld_o),
		.head_idx_i        (head_idx),
		.recover_idx_i     (resolve_idx_i),
		.head_done_o       (head_done),
		.head_new_tag_o    (retire_new_tag_o),
		.head_old_tag_o    (retire_old_tag_o),
		.head_areg_o       (retire_areg_o),
		.recover_fl_head_o (recover_fl_head_o)
	);

	rob_branch_store rob_branch_store_i (
		.clk            (clk),
		.rst            (rst),
		.alloc_en_i     (alloc_en),
		.tail_idx_i     (tail_idx),
		.pc_i           (pc_i),
		.br_flag_i      (br_flag_i),
		.br_pretaken_i  (br_pretaken_i),
		.br_target_i    (br_target_i),
		.br_mask_i      (br_mask_i),
		.npc_idx_i      (npc_idx_i),
		.recover_idx_i  (resolve_idx_i),
		.npc_o          (npc_o),
		.rec_br_flag_o  (rec_br_flag),
		.rec_pretaken_o (rec_pretaken),
		.rec_target_o   (rec_target),
		.recover_mask_o (recover_mask_o)
	);

	// ----------------------------------------
	// early recovery
	// ----------------------------------------
	rob_recovery rob_recovery_i (
		.clk              (clk),
		.rst              (rst),
		.resolve_i        (resolve_i),
		.resolve_taken_i  (resolve_taken_i),
		.resolve_target_i (resolve_target_i),
		.rec_br_flag_i    (rec_br_flag),
		.rec_pretaken_i   (rec_pretaken),
		.rec_target_i     (rec_target),
		.br_outcome_o     (br_outcome_o),
		.rollback_o       (rollback)
	);

endmodule

//--- tb_rob.sv
`timescale 1ns/1ps

module tb_rob;
	import rob_cfg_pkg::*;
	import rob_types_pkg::*;

	typedef enum logic [2:0] {CMD_DISP, CMD_COMP, CMD_RES, CMD_IDLE, CMD_NPC} cmd_e;
	typedef logic [7:0][63:0] args_t;

	logic clk, rst;
	logic dispatch_i, br_flag_i, br_pretaken_i;
	logic complete_i, resolve_i, resolve_taken_i;
	prf_tag_t new_tag_i, old_tag_i, retire_old_tag_o, retire_new_tag_o;
	areg_t areg_i, retire_areg_o;
	fl_head_t fl_head_i, recover_fl_head_o;
	pc_t pc_i, br_target_i, resolve_target_i, npc_o;
	br_mask_t br_mask_i, recover_mask_o;
	rob_idx_t complete_idx_i, resolve_idx_i, npc_idx_i;
	rob_ptr_t tail_ptr_o;
	logic stall_o, retire_vld_o;
	br_outcome_e br_outcome_o;

	rob_top rob_top_i (.*);

	cmd_e cmd_q[$];
	args_t arg_q[$];
	int n_cmds = 0;

	// reference model
	rob_ptr_t head_m, tail_m;
	logic [ROB_DEPTH-1:0] done_m;
	logic [16:0] ret_q[$]; // {new tag, old tag, areg} in dispatch order
	logic rvld_m, alloc_m, rollback_m;

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ----------------------------------------
	// compare tasks
	// ----------------------------------------
	task automatic fail_run(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic report(input string what, input logic [63:0] got, input logic [63:0] exp);
		fail_run($sformatf("MISMATCH at %0t ns: %s got %0h expected %0h",
			$time, what, got, exp));
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp) report(what, 64'(got), 64'(exp));
	endtask
	task automatic check_tag(input prf_tag_t got, input prf_tag_t exp, input string what);
		if (got !== exp) report(what, 64'(got), 64'(exp));
	endtask
	task automatic check_areg(input areg_t got, input areg_t exp, input string what);
		if (got !== exp) report(what, 64'(got), 64'(exp));
	endtask
	task automatic check_ptr(input rob_ptr_t got, input rob_ptr_t exp, input string what);
		if (got !== exp) report(what, 64'(got), 64'(exp));
	endtask
	task automatic check_pc(input pc_t got, input pc_t exp, input string what);
		if (got !== exp) report(what, got, exp);
	endtask
	task automatic check_mask(input br_mask_t got, input br_mask_t exp, input string what);
		if (got !== exp) report(what, 64'(got), 64'(exp));
	endtask
	task automatic check_flh(input fl_head_t got, input fl_head_t exp, input string what);
		if (got !== exp) report(what, 64'(got), 64'(exp));
	endtask
	task automatic check_outcome(input br_outcome_e got, input br_outcome_e exp);
		if (got !== exp) report("branch outcome", 64'(got), 64'(exp));
	endtask

	// ----------------------------------------
	// per-cycle model
	// ----------------------------------------
	// compares the outputs with the model at the falling edge
	task automatic sample_cycle();
		rob_ptr_t cnt;
		cnt = tail_m - head_m;
		rvld_m = (cnt != 0) && done_m[head_m[ROB_IDX_W-1:0]];
		alloc_m = dispatch_i && !((cnt == ROB_DEPTH) && !rvld_m) && !rollback_m;
		check_bit(retire_vld_o, rvld_m, "retire_vld_o");
		check_bit(stall_o, (cnt == ROB_DEPTH) && !rvld_m, "stall_o");
		check_ptr(tail_ptr_o, tail_m, "tail_ptr_o");
		if (rvld_m) begin
			check_tag(retire_new_tag_o, ret_q[0][16:11], "retire new tag");
			check_tag(retire_old_tag_o, ret_q[0][10:5], "retire old tag");
			check_areg(retire_areg_o, ret_q[0][4:0], "retire areg");
		end
	endtask

	task automatic update_model();
		rob_idx_t pos;
		if (rvld_m)
			done_m[head_m[ROB_IDX_W-1:0]] = 1'b0;
		if (rollback_m) begin
			pos = resolve_idx_i - head_m[ROB_IDX_W-1:0]; // distance from head
			while (ret_q.size() > int'(pos) + 1)
				void'(ret_q.pop_back());
			tail_m = head_m + rob_ptr_t'(pos) + 1;
		end else if (alloc_m) begin
			done_m[tail_m[ROB_IDX_W-1:0]] = 1'b0;
			ret_q.push_back({new_tag_i, old_tag_i, areg_i});
			tail_m = tail_m + 1;
		end
		if (rvld_m) begin
			void'(ret_q.pop_front());
			head_m = head_m + 1;
		end
		if (complete_i)
			done_m[complete_idx_i] = 1'b1;
	endtask

	task automatic clear_strobes();
		dispatch_i <= 1'b0;
		complete_i <= 1'b0;
		resolve_i <= 1'b0;
	endtask

	// ----------------------------------------
	// stimulus file
	// ----------------------------------------
	task automatic load_stimulus();
		int fd, r;
		string line, name;
		logic [63:0] a0, a1, a2, a3, a4, a5, a6, a7;
		fd = $fopen("rob_stimulus.txt", "r");
		if (fd == 0)
			fail_run("cannot open rob_stimulus.txt");
		while (!$feof(fd)) begin
			r = $fgets(line, fd);
			if (r == 0)
				break;
			if (line.len() < 2 || line[0] == "#")
				continue;
			r = $sscanf(line, "%s %h %h %h %h %h %h %h %h",
				name, a0, a1, a2, a3, a4, a5, a6, a7);
			if (r != 9)
				fail_run($sformatf("bad stimulus line: %s", line));
			case (name)
				"disp": cmd_q.push_back(CMD_DISP);
				"comp": cmd_q.push_back(CMD_COMP);
				"res":  cmd_q.push_back(CMD_RES);
				"idle": cmd_q.push_back(CMD_IDLE);
				"npc":  cmd_q.push_back(CMD_NPC);
				default: fail_run($sformatf("unknown command %s", name));
			endcase
			arg_q.push_back({a7, a6, a5, a4, a3, a2, a1, a0});
		end
		$fclose(fd);
		if (cmd_q.size() == 0)
			fail_run("the stimulus file holds no commands");
		n_cmds = cmd_q.size();
	endtask

	initial begin
		wait (n_cmds != 0);
		#(longint'(n_cmds + 10) * 20 * 100);
		$display("timeout: the run did not finish in time");
		$display("*** TEST FAILED ***");
		$fatal(1, "watchdog expired");
	end

	initial begin
		args_t a;
		prf_tag_t tag;
		int cycles;
		rst = 1'b1;
		dispatch_i = 1'b0;
		br_flag_i = 1'b0;
		br_pretaken_i = 1'b0;
		complete_i = 1'b0;
		resolve_i = 1'b0;
		resolve_taken_i = 1'b0;
		new_tag_i = '0;
		old_tag_i = '0;
		areg_i = '0;
		fl_head_i = '0;
		pc_i = '0;
		br_target_i = '0;
		resolve_target_i = '0;
		br_mask_i = '0;
		complete_idx_i = '0;
		resolve_idx_i = '0;
		npc_idx_i = '0;
		head_m = '0;
		tail_m = '0;
		done_m = '0;
		rollback_m = 1'b0;
		load_stimulus();
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		foreach (cmd_q[c]) begin
			a = arg_q[c];
			case (cmd_q[c])
				CMD_COMP: cycles = int'(a[2]); // count sits in the third column
				CMD_RES, CMD_NPC: cycles = 1;
				default: cycles = int'(a[0]);
			endcase
			for (int k = 0; k < cycles; k++) begin
				clear_strobes();
				rollback_m = 1'b0;
				tag = prf_tag_t'(a[1]) + prf_tag_t'(k);
				case (cmd_q[c])
					CMD_DISP: begin
						dispatch_i <= 1'b1;
						new_tag_i <= tag;
						old_tag_i <= tag ^ 6'h2a; // derived fields
						areg_i <= tag[4:0];
						fl_head_i <= tag[4:0] ^ 5'h0f;
						pc_i <= a[2] + pc_t'(8 * k);
						br_flag_i <= a[3][0];
						br_pretaken_i <= a[4][0];
						br_target_i <= a[5];
						br_mask_i <= br_mask_t'(a[6]);
					end
					CMD_COMP: begin
						complete_i <= 1'b1;
						complete_idx_i <= rob_idx_t'(a[0] + a[1] * k);
					end
					CMD_RES: begin
						resolve_i <= 1'b1;
						resolve_idx_i <= rob_idx_t'(a[0]);
						resolve_taken_i <= a[1][0];
						resolve_target_i <= a[2];
						rollback_m = (br_outcome_e'(a[3][1:0]) == BR_MISPREDICT);
					end
					CMD_NPC: npc_idx_i <= rob_idx_t'(a[0]);
					default: ;
				endcase
				@(negedge clk);
				sample_cycle();
				if (cmd_q[c] == CMD_DISP)
					check_bit(stall_o, a[7][0], "stall_o from file");
				if (cmd_q[c] == CMD_RES) begin
					check_outcome(br_outcome_o, br_outcome_e'(a[3][1:0]));
					if (rollback_m) begin
						check_flh(recover_fl_head_o, fl_head_t'(a[4]), "recover fl head");
						check_mask(recover_mask_o, br_mask_t'(a[5]), "recover mask");
					end
				end else begin
					check_outcome(br_outcome_o, BR_NONE); // nothing resolves here
				end
				if (cmd_q[c] == CMD_NPC)
					check_pc(npc_o, a[1], "npc_o");
				@(posedge clk);
				update_model();
			end
		end
		clear_strobes();
		if (ret_q.size() != 0) begin
			fail_run("entries were left in the buffer at the end");
		end else begin
			$display("*** TEST PASSED ***");
			$finish;
		end
	end

endmodule

//--- rob_stimulus.txt
# cmd a0..a7 in hex. disp: count tag_base pc_base br_flag pretaken target mask exp_stall
# comp: first_idx stride count; res: idx taken target exp_outcome exp_fl_head exp_mask; idle: cycles; npc: idx exp_npc
disp 20 00 1000 0 0 0 0 0
disp 1 3f 9000 0 0 0 0 1
comp 3 7 20 0 0 0 0 0
idle 22 0 0 0 0 0 0 0
disp 4 10 2000 0 0 0 0 0
comp 0 1 4 0 0 0 0 0
idle 6 0 0 0 0 0 0 0
disp 1 20 3000 1 1 3400 5 0
disp 3 21 3004 0 0 0 0 0
res 4 1 3400 1 0 0 0 0
disp 1 24 4000 1 0 4100 9 0
disp 2 25 4004 0 0 0 0 0
res 8 1 4100 2 0b 9 0 0
res 8 1 4100 0 0 0 0 0
res 5 0 0 0 0 0 0 0
res 4 1 3408 2 0f 5 0 0
npc 4 3004 0 0 0 0 0 0
npc 0 2004 0 0 0 0 0 0
comp 4 1 1 0 0 0 0 0
idle 4 0 0 0 0 0 0 0

//--- all.f
rob_cfg_pkg.sv
rob_types_pkg.sv
rob_ptrs.sv
rob_entry_store.sv
rob_branch_store.sv
rob_recovery.sv
rob_top.sv
tb_rob.sv

//--- Makefile
VERILATOR ?= verilator
TB_TOP ?= tb_rob
RTL_TOP ?= rob_top
FILELIST ?= all.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TB_TOP): $(FILELIST) *.sv
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

run: $(OBJ_DIR)/V$(TB_TOP)
	./$(OBJ_DIR)/V$(TB_TOP)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TB_TOP)

clean:
	rm -rf $(OBJ_DIR)
